/* all.f */
gat_pkg.sv
gat_weight_store.sv
gat_spmm_engine.sv
gat_attention_scorer.sv
gat_coef_fifo.sv
gat_conv_top.sv
tb_clock_gen.sv
tb_gat_conv.sv

/* Bender.yml */
package:
  name: gat_conv

sources:
  - gat_pkg.sv
  - gat_weight_store.sv
  - gat_spmm_engine.sv
  - gat_attention_scorer.sv
  - gat_coef_fifo.sv
  - gat_conv_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_gat_conv.sv

/* tb_gat_conv.sv */
`timescale 1ns/1ps

module tb_gat_conv;
  import gat_pkg::*;

  localparam int NFI         = 16;
  localparam int NFO         = 4;
  localparam int COEF_DEPTH  = 8;
  localparam int W_SIZE      = NFI * NFO;
  localparam int ADDR_SPACE  = W_SIZE + 2 * NFO;
  localparam int ADDR_W      = $clog2(ADDR_SPACE);
  localparam int ROW_W       = $clog2(NFI);
  localparam int SINGLE_ROWS = 16;
  localparam int MULTI_ROWS  = 24;
  localparam int SUBGRAPHS   = 12;
  localparam int NZ_BOUND    = SINGLE_ROWS + 6 * MULTI_ROWS + 24 * SUBGRAPHS + 6 * (COEF_DEPTH + 1);
  localparam int LIMIT       = 20 * NZ_BOUND + 2 * (ADDR_SPACE + 1) + 5;

  logic clk, rst_n;
  logic wgt_we_i, nz_vld_i, nz_first_i, nz_last_i, coef_pop_i;
  logic [ADDR_W-1:0] wgt_addr_i;
  data_t wgt_data_i, nz_val_i, coef_o;
  logic [ROW_W-1:0] nz_col_i;
  logic wh_vld_o, coef_empty_o, coef_ovf_o;
  wh_t [NFO-1:0] wh_row_o;

  data_t w_ref [NFI][NFO];
  data_t [NFO-1:0] a1_ref;
  data_t [NFO-1:0] a2_ref;
  score_t target_term;
  logic [15:0] lfsr_q;
  logic pop_en;
  logic nz_last_seen;
  logic [NFO*WH_DATA_WIDTH-1:0] exp_wh_q [$];
  data_t exp_coef_q [$];

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  gat_conv_top #(.NUM_FEATURE_IN(NFI), .NUM_FEATURE_OUT(NFO), .COEF_DEPTH(COEF_DEPTH)) dut_i (
    .clk(clk), .rst_n(rst_n), .wgt_we_i(wgt_we_i), .wgt_addr_i(wgt_addr_i),
    .wgt_data_i(wgt_data_i), .nz_vld_i(nz_vld_i), .nz_val_i(nz_val_i), .nz_col_i(nz_col_i),
    .nz_first_i(nz_first_i), .nz_last_i(nz_last_i), .wh_vld_o(wh_vld_o), .wh_row_o(wh_row_o),
    .coef_pop_i(coef_pop_i), .coef_o(coef_o), .coef_empty_o(coef_empty_o),
    .coef_ovf_o(coef_ovf_o)
  );

  task automatic stop_run(input string why);
    $display("Error at %0t: %s", $time, why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [79:0] exp, input logic [79:0] act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic data_t rand_signed(input int n);
    logic signed [31:0] t;
    t = next_bits(n) << (32 - n);
    return data_t'(t >>> (32 - n));
  endfunction

  function automatic score_t dot(input data_t [NFO-1:0] a, input wh_t [NFO-1:0] wh);
    longint s;
    s = 0;
    for (int k = 0; k < NFO; k++) begin
      s += longint'(a[k]) * longint'(wh[k]);
    end
    return score_t'(s);
  endfunction

  // LeakyReLU, scale and saturate
  function automatic data_t coef_of(input score_t x);
    longint v;
    v = x;
    if (v < 0) begin
      v = v >>> LEAKY_SHIFT;
    end
    v = v >>> COEF_SHIFT;
    if (v > 127) v = 127;
    if (v < -128) v = -128;
    return data_t'(v);
  endfunction

  task automatic load_weights(input int wbits, input int abits);
    data_t d;
    for (int addr = 0; addr < ADDR_SPACE; addr++) begin
      d = rand_signed(addr < W_SIZE ? wbits : abits);
      if (addr < W_SIZE) w_ref[addr / NFO][addr % NFO] = d;
      else if (addr < W_SIZE + NFO) a1_ref[addr - W_SIZE] = d;
      else a2_ref[addr - W_SIZE - NFO] = d;
      @(posedge clk);
      wgt_we_i   <= 1'b1;
      wgt_addr_i <= ADDR_W'(addr);
      wgt_data_i <= d;
    end
    @(posedge clk);
    wgt_we_i <= 1'b0;
  endtask

  task automatic send_row(input int n_nz, input bit first, input int val_bits, input bit keep);
    logic [ROW_W-1:0] col;
    data_t val;
    longint lane [NFO];
    wh_t [NFO-1:0] wh;
    for (int k = 0; k < NFO; k++) lane[k] = 0;
    for (int i = 0; i < n_nz; i++) begin
      col = next_bits(ROW_W);
      val = rand_signed(val_bits);
      for (int k = 0; k < NFO; k++) lane[k] += longint'(val) * longint'(w_ref[col][k]);
      @(posedge clk);
      nz_vld_i   <= 1'b1;
      nz_val_i   <= val;
      nz_col_i   <= col;
      nz_first_i <= first && (i == 0);
      nz_last_i  <= (i == n_nz - 1);
    end
    // Lanes keep the low 20 bits
    for (int k = 0; k < NFO; k++) wh[k] = wh_t'(lane[k]);
    exp_wh_q.push_back(wh);
    if (first) target_term = dot(a1_ref, wh);
    if (keep) exp_coef_q.push_back(coef_of(target_term + dot(a2_ref, wh)));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      nz_vld_i   <= 1'b0;
      nz_first_i <= 1'b0;
      nz_last_i  <= 1'b0;
    end
  endtask

  task automatic drain();
    while (exp_wh_q.size() != 0 || exp_coef_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    check_value("coef_empty_o", 1, coef_empty_o);
  endtask

  // Wh monitor, one row per wh_vld_o pulse
  always @(posedge clk) begin
    if (rst_n) begin
      check_value("wh_vld_o", nz_last_seen, wh_vld_o);
      nz_last_seen = nz_vld_i && nz_last_i;
      if (wh_vld_o) begin
        if (exp_wh_q.size() == 0) begin
          stop_run("Wh row arrived with none expected");
        end else begin
          check_value("wh_row_o", exp_wh_q.pop_front(), wh_row_o);
        end
      end
    end
  end

  // Pops every other cycle so the head is never stale
  always @(posedge clk) begin
    if (!rst_n || coef_pop_i) begin
      coef_pop_i <= 1'b0;
    end else if (pop_en && !coef_empty_o) begin
      if (exp_coef_q.size() == 0) begin
        stop_run("coefficient in FIFO with none expected");
      end else begin
        check_value("coef_o", exp_coef_q.pop_front(), coef_o);
        coef_pop_i <= 1'b1;
      end
    end
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    stop_run("simulation timed out waiting for the DUT");
  end

  initial begin
    wgt_we_i     = 1'b0;
    wgt_addr_i   = '0;
    wgt_data_i   = '0;
    nz_vld_i     = 1'b0;
    nz_val_i     = '0;
    nz_col_i     = '0;
    nz_first_i   = 1'b0;
    nz_last_i    = 1'b0;
    coef_pop_i   = 1'b0;
    pop_en       = 1'b1;
    nz_last_seen = 1'b0;
    target_term  = '0;
    lfsr_q       = 16'd97;
    while (rst_n !== 1'b1) @(posedge clk);
    @(posedge clk);
    check_value("coef_empty_o", 1, coef_empty_o);
    check_value("coef_ovf_o", 0, coef_ovf_o);
    check_value("wh_vld_o", 0, wh_vld_o);
    check_value("coef_o", 0, coef_o);
    // Full range weights for the Wh checks
    load_weights(8, 8);
    for (int r = 0; r < SINGLE_ROWS; r++) begin
      send_row(1, 1'b1, 8, 1'b1);
      idle(1);
    end
    for (int r = 0; r < MULTI_ROWS; r++) begin
      send_row(1 + next_bits(3) % 6, 1'b1, 8, 1'b1);
      idle(1);
    end
    drain();
    // Small weights so scores land on both sides and sometimes saturate
    load_weights(5, 4);
    for (int g = 0; g < SUBGRAPHS; g++) begin
      int nodes;
      nodes = 1 + next_bits(2);
      for (int n = 0; n < nodes; n++) begin
        send_row(2 + next_bits(3) % 5, n == 0, 4, 1'b1);
      end
    end
    idle(1);
    drain();
    check_value("coef_ovf_o", 0, coef_ovf_o);
    pop_en <= 1'b0;
    for (int r = 0; r <= COEF_DEPTH; r++) begin
      send_row(1 + next_bits(3) % 6, r == 0, 4, r < COEF_DEPTH);
    end
    idle(1);
    while (!coef_ovf_o) @(posedge clk);
    check_value("coef_empty_o", 0, coef_empty_o);
    pop_en <= 1'b1;
    drain();
    check_value("coef_ovf_o", 1, coef_ovf_o);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* gat_conv_top.sv */
`timescale 1ns/1ps

module gat_conv_top #(
  parameter int NUM_FEATURE_IN  = 16,
  parameter int NUM_FEATURE_OUT = 4,
  parameter int COEF_DEPTH      = 8,
  localparam int ADDR_W = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT),
  localparam int ROW_W  = $clog2(NUM_FEATURE_IN)
)(
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                wgt_we_i,
  input  logic [ADDR_W-1:0]                   wgt_addr_i,
  input  gat_pkg::data_t                      wgt_data_i,
  input  logic                                nz_vld_i,
  input  gat_pkg::data_t                      nz_val_i,
  input  logic [ROW_W-1:0]                    nz_col_i,
  input  logic                                nz_first_i,
  input  logic                                nz_last_i,
  output logic                                wh_vld_o,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]  wh_row_o,
  input  logic                                coef_pop_i,
  output gat_pkg::data_t                      coef_o,
  output logic                                coef_empty_o,
  output logic                                coef_ovf_o
);
  import gat_pkg::*;

  logic [ROW_W-1:0]             w_row_sel;
  data_t [NUM_FEATURE_OUT-1:0]  w_row;
  data_t [NUM_FEATURE_OUT-1:0]  a1_vec;
  data_t [NUM_FEATURE_OUT-1:0]  a2_vec;
  logic                         wh_first;
  logic                         coef_push;
  data_t                        coef_data;

  gat_weight_store #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN ),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_weight_store (
    .clk         (clk       ),
    .rst_n       (rst_n     ),
    .wgt_we_i    (wgt_we_i  ),
    .wgt_addr_i  (wgt_addr_i),
    .wgt_data_i  (wgt_data_i),
    .w_row_sel_i (w_row_sel ),
    .w_row_o     (w_row     ),
    .a1_vec_o    (a1_vec    ),
    .a2_vec_o    (a2_vec    )
  );

  gat_spmm_engine #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN ),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_spmm_engine (
    .clk         (clk       ),
    .rst_n       (rst_n     ),
    .nz_vld_i    (nz_vld_i  ),
    .nz_val_i    (nz_val_i  ),
    .nz_col_i    (nz_col_i  ),
    .nz_first_i  (nz_first_i),
    .nz_last_i   (nz_last_i ),
    .w_row_sel_o (w_row_sel ),
    .w_row_i     (w_row     ),
    .wh_vld_o    (wh_vld_o  ),
    .wh_row_o    (wh_row_o  ),
    .wh_first_o  (wh_first  )
  );

  gat_attention_scorer #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) u_attention_scorer (
    .clk         (clk      ),
    .rst_n       (rst_n    ),
    .wh_vld_i    (wh_vld_o ),
    .wh_row_i    (wh_row_o ),
    .wh_first_i  (wh_first ),
    .a1_vec_i    (a1_vec   ),
    .a2_vec_i    (a2_vec   ),
    .coef_push_o (coef_push),
    .coef_data_o (coef_data)
  );

  gat_coef_fifo #(
    .COEF_DEPTH (COEF_DEPTH)
  ) u_coef_fifo (
    .clk         (clk         ),
    .rst_n       (rst_n       ),
    .push_i      (coef_push   ),
    .push_data_i (coef_data   ),
    .pop_i       (coef_pop_i  ),
    .head_o      (coef_o      ),
    .empty_o     (coef_empty_o),
    .ovf_o       (coef_ovf_o  )
  );

endmodule

/* gat_coef_fifo.sv */
`timescale 1ns/1ps

module gat_coef_fifo #(
  parameter int COEF_DEPTH = 8,
  localparam int PTR_W     = $clog2(COEF_DEPTH),
  localparam int CNT_W     = $clog2(COEF_DEPTH + 1)
)(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           push_i,
  input  gat_pkg::data_t push_data_i,
  input  logic           pop_i,
  output gat_pkg::data_t head_o,
  output logic           empty_o,
  output logic           ovf_o
);
  import gat_pkg::*;

  data_t            mem [COEF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full    = (count_q == CNT_W'(COEF_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_pop  = pop_i && !empty_o;
  // A pop frees the slot even when full
  assign do_push = push_i && (!full || pop_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ovf_o    <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(COEF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(COEF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
      if (push_i && !do_push) begin
        ovf_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign head_o = empty_o ? '0 : mem[rd_ptr_q];

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !empty_o);

endmodule

/* gat_attention_scorer.sv */
`timescale 1ns/1ps

module gat_attention_scorer #(
  parameter int NUM_FEATURE_OUT = 4
)(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wh_vld_i,
  input  gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]    wh_row_i,
  input  logic                                  wh_first_i,
  input  gat_pkg::data_t [NUM_FEATURE_OUT-1:0]  a1_vec_i,
  input  gat_pkg::data_t [NUM_FEATURE_OUT-1:0]  a2_vec_i,
  output logic                                  coef_push_o,
  output gat_pkg::data_t                        coef_data_o
);
  import gat_pkg::*;

  localparam score_t COEF_MAX = 127;
  localparam score_t COEF_MIN = -128;

  score_t s1;
  score_t s2;
  score_t s1_q;
  score_t s2_q;
  logic   vld_q;
  logic   first_q;
  score_t target_q;
  score_t score;
  score_t leaky;
  score_t scaled;
  data_t  coef;

  // Stage 1 dot products
  always_comb begin
    s1 = '0;
    s2 = '0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      s1 = s1 + score_t'(a1_vec_i[k]) * score_t'(wh_row_i[k]);
      s2 = s2 + score_t'(a2_vec_i[k]) * score_t'(wh_row_i[k]);
    end
  end

  // Target row supplies its own a1 term
  always_comb begin
    score  = (first_q ? s1_q : target_q) + s2_q;
    leaky  = score[SCORE_WIDTH-1] ? (score >>> LEAKY_SHIFT) : score;
    scaled = leaky >>> COEF_SHIFT;
    if (scaled > COEF_MAX) begin
      coef = data_t'(COEF_MAX);
    end else if (scaled < COEF_MIN) begin
      coef = data_t'(COEF_MIN);
    end else begin
      coef = data_t'(scaled);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q       <= 1'b0;
      first_q     <= 1'b0;
      target_q    <= '0;
      coef_push_o <= 1'b0;
    end else begin
      vld_q       <= wh_vld_i;
      first_q     <= wh_first_i;
      coef_push_o <= vld_q;
      if (vld_q && first_q) begin
        target_q <= s1_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      s1_q <= s1;
      s2_q <= s2;
    end
    if (vld_q) begin
      coef_data_o <= coef;
    end
  end

endmodule

/* gat_spmm_engine.sv */
`timescale 1ns/1ps

module gat_spmm_engine #(
  parameter int NUM_FEATURE_IN  = 16,
  parameter int NUM_FEATURE_OUT = 4,
  localparam int ROW_W          = $clog2(NUM_FEATURE_IN)
)(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  nz_vld_i,
  input  gat_pkg::data_t                        nz_val_i,
  input  logic [ROW_W-1:0]                      nz_col_i,
  input  logic                                  nz_first_i,
  input  logic                                  nz_last_i,
  output logic [ROW_W-1:0]                      w_row_sel_o,
  input  gat_pkg::data_t [NUM_FEATURE_OUT-1:0]  w_row_i,
  output logic                                  wh_vld_o,
  output gat_pkg::wh_t [NUM_FEATURE_OUT-1:0]    wh_row_o,
  output logic                                  wh_first_o
);
  import gat_pkg::*;

  row_state_e                 state_q;
  logic                       first_q;
  wh_t [NUM_FEATURE_OUT-1:0]  acc_q;
  wh_t [NUM_FEATURE_OUT-1:0]  acc_next;
  logic                       row_start;

  // Column index picks the W row for this nonzero
  assign w_row_sel_o = nz_col_i;
  assign row_start   = (state_q == row_idle_s);

  always_comb begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      acc_next[k] = acc_q[k] + wh_t'(nz_val_i) * wh_t'(w_row_i[k]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= row_idle_s;
      first_q    <= 1'b0;
      acc_q      <= '0;
      wh_vld_o   <= 1'b0;
      wh_first_o <= 1'b0;
    end else begin
      wh_vld_o <= 1'b0;
      if (nz_vld_i) begin
        if (nz_last_i) begin
          // Lanes cleared so a new row can start next cycle
          state_q    <= row_idle_s;
          acc_q      <= '0;
          wh_vld_o   <= 1'b1;
          wh_first_o <= row_start ? nz_first_i : first_q;
        end else begin
          state_q <= row_accum_s;
          acc_q   <= acc_next;
          if (row_start) begin
            first_q <= nz_first_i;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (nz_vld_i && nz_last_i) begin
      wh_row_o <= acc_next;
    end
  end

  a_nz_col_range: assert property (@(posedge clk) disable iff (!rst_n)
    nz_vld_i |-> (int'(nz_col_i) < NUM_FEATURE_IN));

endmodule

/* gat_weight_store.sv */
`timescale 1ns/1ps

module gat_weight_store #(
  parameter int NUM_FEATURE_IN  = 16,
  parameter int NUM_FEATURE_OUT = 4,
  localparam int W_SIZE         = NUM_FEATURE_IN * NUM_FEATURE_OUT,
  localparam int ADDR_SPACE     = W_SIZE + 2 * NUM_FEATURE_OUT,
  localparam int ADDR_W         = $clog2(ADDR_SPACE),
  localparam int ROW_W          = $clog2(NUM_FEATURE_IN)
)(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wgt_we_i,
  input  logic [ADDR_W-1:0]                     wgt_addr_i,
  input  gat_pkg::data_t                        wgt_data_i,
  input  logic [ROW_W-1:0]                      w_row_sel_i,
  output gat_pkg::data_t [NUM_FEATURE_OUT-1:0]  w_row_o,
  output gat_pkg::data_t [NUM_FEATURE_OUT-1:0]  a1_vec_o,
  output gat_pkg::data_t [NUM_FEATURE_OUT-1:0]  a2_vec_o
);
  import gat_pkg::*;

  data_t [NUM_FEATURE_OUT-1:0] w_q [NUM_FEATURE_IN];
  data_t [NUM_FEATURE_OUT-1:0] a1_q;
  data_t [NUM_FEATURE_OUT-1:0] a2_q;

  // Weights row by row, then a1, then a2
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        w_q[r] <= '0;
      end
      a1_q <= '0;
      a2_q <= '0;
    end else if (wgt_we_i) begin
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
          if (wgt_addr_i == ADDR_W'(r * NUM_FEATURE_OUT + c)) begin
            w_q[r][c] <= wgt_data_i;
          end
        end
      end
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        if (wgt_addr_i == ADDR_W'(W_SIZE + c)) begin
          a1_q[c] <= wgt_data_i;
        end
        if (wgt_addr_i == ADDR_W'(W_SIZE + NUM_FEATURE_OUT + c)) begin
          a2_q[c] <= wgt_data_i;
        end
      end
    end
  end

  assign w_row_o  = w_q[w_row_sel_i];
  assign a1_vec_o = a1_q;
  assign a2_vec_o = a2_q;

  a_wgt_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    wgt_we_i |-> (int'(wgt_addr_i) < ADDR_SPACE));

endmodule

/* gat_pkg.sv */
package gat_pkg;

  // Datapath widths
  localparam int DATA_WIDTH    = 8;
  localparam int WH_DATA_WIDTH = 20;
  localparam int SCORE_WIDTH   = 32;

  // Negative slope of LeakyReLU is 1/8
  localparam int LEAKY_SHIFT = 3;
  // Scale from attention score down to coefficient
  localparam int COEF_SHIFT  = 6;

  // Feature values, weights, a entries and coefficients
  typedef logic signed [DATA_WIDTH-1:0] data_t;

  // One lane of a Wh row
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_t;

  // Attention score before LeakyReLU
  typedef logic signed [SCORE_WIDTH-1:0] score_t;

  // Row accumulation in the SPMM engine
  typedef enum logic {
    row_idle_s,
    row_accum_s
  } row_state_e;

endpackage
